// ==== verilog/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int xlen = 32;

    // load/store kinds carried through the stage
    typedef enum logic [2:0] {
        ld_b  = 3'd0,
        ld_bu = 3'd1,
        ld_h  = 3'd2,
        ld_hu = 3'd3,
        ld_w  = 3'd4,
        st_b  = 3'd5,
        st_h  = 3'd6,
        st_w  = 3'd7
    } mem_op_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef enum logic [2:0] {
        exc_none          = 3'd0,
        exc_ale           = 3'd1,
        exc_tlb_refill    = 3'd2,
        exc_load_invalid  = 3'd3,
        exc_store_invalid = 3'd4,
        exc_plv_invalid   = 3'd5,
        exc_store_dirty   = 3'd6
    } exc_code_t;

    function automatic logic op_is_store(input mem_op_t op);
        return op inside {st_b, st_h, st_w};
    endfunction

    function automatic mem_size_t op_size(input mem_op_t op);
        case (op)
            ld_b, ld_bu, st_b: return size_byte;
            ld_h, ld_hu, st_h: return size_half;
            default:           return size_word;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== verilog/mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

    // one direct-mapped window, vseg selects and pseg replaces va[31:29]
    typedef struct packed {
        logic       plv0;   // usable at plv 0
        logic       plv3;   // usable at plv 3
        logic [1:0] mat;
        logic [2:0] pseg;
        logic [2:0] vseg;
    } dmw_cfg_t;

    // answer of the external tlb for the current vppn
    typedef struct packed {
        logic        found;
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic        d;
        logic        v;
        logic [1:0]  mat;
    } tlb_result_t;

    // da/pg pairs other than 10 and 01 are illegal
    typedef enum logic [1:0] {
        xlat_direct  = 2'd0,
        xlat_mapped  = 2'd1,
        xlat_illegal = 2'd2
    } xlat_mode_t;

endpackage

`default_nettype wire

// ==== verilog/xlat_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface xlat_if import ex_pkg::*; ();

    logic [xlen-1:0] vaddr;
    logic            is_load;
    logic            is_store;
    logic [xlen-1:0] paddr;
    logic            uncache;
    exc_code_t       tlb_exc;   // exc_none when translation is clean

    modport requester (output vaddr, output is_load, output is_store);

    modport translator (
        input  vaddr, is_load, is_store,
        output paddr, uncache, tlb_exc
    );

    modport consumer (input vaddr, is_load, is_store, paddr, uncache, tlb_exc);

endinterface

`default_nettype wire

// ==== verilog/ex_stage_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg import ex_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            in_valid,
    input  logic [xlen-1:0] in_pc,
    input  logic [xlen-1:0] in_rj,
    input  logic [xlen-1:0] in_imm,
    input  logic [xlen-1:0] in_rkd,
    input  mem_op_t         in_op,
    input  logic            ready_go,
    input  logic            ms_allow_in,
    output logic            allow_in,
    output logic            valid,
    output logic [xlen-1:0] pc,
    output mem_op_t         op,
    output logic [xlen-1:0] rkd,
    xlat_if.requester       xlat
);

    logic [xlen-1:0] rj;
    logic [xlen-1:0] imm;

    // empty, or the held item leaves this cycle
    assign allow_in = !valid || (ready_go && ms_allow_in);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            valid <= 1'b0;
        end else if (allow_in) begin
            valid <= in_valid;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (in_valid && allow_in) begin
            pc  <= in_pc;
            rj  <= in_rj;
            imm <= in_imm;
            rkd <= in_rkd;
            op  <= in_op;
        end
    end

    assign xlat.vaddr    = rj + imm;   // effective address
    assign xlat.is_store = op_is_store(op);
    assign xlat.is_load  = !op_is_store(op);

endmodule

`default_nettype wire

// ==== verilog/addr_translate.sv ====
`timescale 1ns/1ps
`default_nettype none

module addr_translate import ex_pkg::*; import mmu_pkg::*; #(
    parameter int dmw_count = 2
) (
    input  logic                       crmd_da,
    input  logic                       crmd_pg,
    input  logic [1:0]                 plv,
    input  logic [1:0]                 datm,
    input  dmw_cfg_t [dmw_count-1:0]   dmw,
    output logic [18:0]                tlb_vppn,
    output logic                       tlb_va_bit12,
    input  tlb_result_t                tlb,
    xlat_if.translator                 xlat
);

    xlat_mode_t           mode;
    logic [dmw_count-1:0] win_match;
    logic                 win_hit;
    logic [2:0]           win_pseg;
    logic [1:0]           win_mat;
    logic                 page;

    always_comb begin
        if (crmd_da && !crmd_pg) begin
            mode = xlat_direct;
        end else if (!crmd_da && crmd_pg) begin
            mode = xlat_mapped;
        end else begin
            mode = xlat_illegal;
        end
    end

    // walk from the top so the lowest matching window is the one kept
    always_comb begin
        win_hit  = 1'b0;
        win_pseg = '0;
        win_mat  = '0;
        for (int i = dmw_count - 1; i >= 0; i--) begin
            win_match[i] = ((plv == 2'd0 && dmw[i].plv0) || (plv == 2'd3 && dmw[i].plv3))
                           && dmw[i].mat == datm
                           && dmw[i].vseg == xlat.vaddr[31:29];
            if (win_match[i]) begin
                win_hit  = 1'b1;
                win_pseg = dmw[i].pseg;
                win_mat  = dmw[i].mat;
            end
        end
    end

    assign page         = (mode == xlat_mapped) && !win_hit;
    assign tlb_vppn     = xlat.vaddr[31:13];
    assign tlb_va_bit12 = xlat.vaddr[12];

    always_comb begin
        case (mode)
            xlat_direct: begin
                xlat.paddr   = xlat.vaddr;
                xlat.uncache = !datm[0];   // mat 1 is coherent cached
            end
            xlat_mapped: begin
                if (win_hit) begin
                    xlat.paddr   = {win_pseg, xlat.vaddr[28:0]};
                    xlat.uncache = !win_mat[0];
                end else begin
                    xlat.paddr   = {tlb.ppn, xlat.vaddr[11:0]};
                    xlat.uncache = !tlb.mat[0];
                end
            end
            default: begin
                xlat.paddr   = '0;
                xlat.uncache = 1'b1;
            end
        endcase
    end

    // page exceptions, first hit wins
    always_comb begin
        if (!page) begin
            xlat.tlb_exc = exc_none;
        end else if (!tlb.found) begin
            xlat.tlb_exc = exc_tlb_refill;
        end else if (!tlb.v) begin
            xlat.tlb_exc = xlat.is_load ? exc_load_invalid : exc_store_invalid;
        end else if (plv > tlb.plv) begin
            xlat.tlb_exc = exc_plv_invalid;
        end else if (xlat.is_store && !tlb.d) begin
            xlat.tlb_exc = exc_store_dirty;
        end else begin
            xlat.tlb_exc = exc_none;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_req_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_req_gen import ex_pkg::*; (
    input  logic            valid,
    input  mem_op_t         op,
    input  logic [xlen-1:0] rkd,
    input  logic            ms_allow_in,
    input  logic            data_sram_addr_ok,
    xlat_if.consumer        xlat,
    output logic            ready_go,
    output exc_code_t       out_exc,
    output logic            data_sram_req,
    output logic            data_sram_wr,
    output mem_size_t       data_sram_size,
    output logic [3:0]      data_sram_wstrb,
    output logic [xlen-1:0] data_sram_addr,
    output logic [xlen-1:0] data_sram_wdata,
    output logic            data_uncache
);

    mem_size_t  size;
    logic [1:0] low;
    logic       ale;
    logic       has_exc;

    assign size = op_size(op);
    assign low  = xlat.paddr[1:0];

    assign ale = (size == size_word && low != 2'b00)
              || (size == size_half && low[0]);

    // misalignment outranks any tlb fault
    assign out_exc = ale ? exc_ale : xlat.tlb_exc;
    assign has_exc = (out_exc != exc_none);

    // hold the request until the next stage can take the item
    assign data_sram_req = valid && ms_allow_in && !has_exc;
    assign ready_go      = has_exc || (data_sram_req && data_sram_addr_ok);

    assign data_sram_wr   = xlat.is_store;
    assign data_sram_size = size;
    assign data_sram_addr = xlat.paddr;
    assign data_uncache   = xlat.uncache;

    always_comb begin
        case (size)
            size_byte: data_sram_wstrb = 4'b0001 << low;
            size_half: data_sram_wstrb = low[1] ? 4'b1100 : 4'b0011;
            default:   data_sram_wstrb = 4'b1111;
        endcase
        if (!xlat.is_store) begin
            data_sram_wstrb = 4'b0000;   // loads write nothing
        end
    end

    always_comb begin
        case (size)
            size_byte: data_sram_wdata = {4{rkd[7:0]}};
            size_half: data_sram_wdata = {2{rkd[15:0]}};
            default:   data_sram_wdata = rkd;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/ex_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_stage import ex_pkg::*; import mmu_pkg::*; #(
    parameter int dmw_count = 2
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     allow_in,
    input  logic [xlen-1:0]          in_pc,
    input  logic [xlen-1:0]          in_rj,
    input  logic [xlen-1:0]          in_imm,
    input  logic [xlen-1:0]          in_rkd,
    input  mem_op_t                  in_op,
    input  logic                     ms_allow_in,
    output logic                     out_valid,
    output logic [xlen-1:0]          out_pc,
    output logic [xlen-1:0]          out_vaddr,
    output exc_code_t                out_exc,
    output logic                     data_sram_req,
    output logic                     data_sram_wr,
    output mem_size_t                data_sram_size,
    output logic [3:0]               data_sram_wstrb,
    output logic [xlen-1:0]          data_sram_addr,
    output logic [xlen-1:0]          data_sram_wdata,
    output logic                     data_uncache,
    input  logic                     data_sram_addr_ok,
    input  logic                     flush,
    input  logic                     crmd_da,
    input  logic                     crmd_pg,
    input  logic [1:0]               plv,
    input  logic [1:0]               datm,
    input  dmw_cfg_t [dmw_count-1:0] dmw,
    output logic [18:0]              tlb_vppn,
    output logic                     tlb_va_bit12,
    input  tlb_result_t              tlb
);

    logic            valid;
    logic            ready_go;
    logic [xlen-1:0] pc;
    mem_op_t         op;
    logic [xlen-1:0] rkd;

    xlat_if xlat ();

    ex_stage_reg u_stage (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_rj       (in_rj),
        .in_imm      (in_imm),
        .in_rkd      (in_rkd),
        .in_op       (in_op),
        .ready_go    (ready_go),
        .ms_allow_in (ms_allow_in),
        .allow_in    (allow_in),
        .valid       (valid),
        .pc          (pc),
        .op          (op),
        .rkd         (rkd),
        .xlat        (xlat.requester)
    );

    addr_translate #(.dmw_count(dmw_count)) u_xlat (
        .crmd_da      (crmd_da),
        .crmd_pg      (crmd_pg),
        .plv          (plv),
        .datm         (datm),
        .dmw          (dmw),
        .tlb_vppn     (tlb_vppn),
        .tlb_va_bit12 (tlb_va_bit12),
        .tlb          (tlb),
        .xlat         (xlat.translator)
    );

    mem_req_gen u_req (
        .valid             (valid),
        .op                (op),
        .rkd               (rkd),
        .ms_allow_in       (ms_allow_in),
        .data_sram_addr_ok (data_sram_addr_ok),
        .xlat              (xlat.consumer),
        .ready_go          (ready_go),
        .out_exc           (out_exc),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_uncache      (data_uncache)
    );

    assign out_valid = valid && ready_go;
    assign out_pc    = pc;
    assign out_vaddr = xlat.vaddr;

endmodule

`default_nettype wire

// ==== include/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// fibonacci lfsr, taps 32 22 2 1, one call per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic mem_size_t model_size(input mem_op_t op);
    if (op == ld_b || op == ld_bu || op == st_b) return size_byte;
    if (op == ld_h || op == ld_hu || op == st_h) return size_half;
    return size_word;
endfunction

function automatic logic [3:0] model_wstrb(input mem_op_t op, input logic [1:0] a);
    case (op)
        st_b:    return 4'b0001 << a;
        st_h:    return a[1] ? 4'b1100 : 4'b0011;
        st_w:    return 4'b1111;
        default: return 4'b0000;
    endcase
endfunction

function automatic logic [31:0] model_wdata(input mem_op_t op, input logic [31:0] rkd);
    mem_size_t s;
    s = model_size(op);
    if (s == size_byte) return {4{rkd[7:0]}};
    if (s == size_half) return {2{rkd[15:0]}};
    return rkd;
endfunction

task automatic model_xlat(input logic da, input logic pg, input logic [1:0] plv,
                          input logic [1:0] datm, input dmw_cfg_t w0, input dmw_cfg_t w1,
                          input tlb_result_t t, input logic [31:0] va, input logic st,
                          output logic [31:0] pa, output logic unc, output exc_code_t exc);
    logic h0;
    logic h1;
    h0 = ((plv == 2'd0 && w0.plv0) || (plv == 2'd3 && w0.plv3))
         && w0.mat == datm && w0.vseg == va[31:29];
    h1 = ((plv == 2'd0 && w1.plv0) || (plv == 2'd3 && w1.plv3))
         && w1.mat == datm && w1.vseg == va[31:29];
    exc = exc_none;
    pa  = '0;
    unc = 1'b1;
    if (da && !pg) begin
        pa  = va;
        unc = !datm[0];
    end else if (!da && pg && h0) begin
        pa  = {w0.pseg, va[28:0]};
        unc = !w0.mat[0];
    end else if (!da && pg && h1) begin
        pa  = {w1.pseg, va[28:0]};
        unc = !w1.mat[0];
    end else if (!da && pg) begin
        pa  = {t.ppn, va[11:0]};
        unc = !t.mat[0];
        if (!t.found) exc = exc_tlb_refill;
        else if (!t.v) exc = st ? exc_store_invalid : exc_load_invalid;
        else if (plv > t.plv) exc = exc_plv_invalid;
        else if (st && !t.d) exc = exc_store_dirty;
    end
endtask

// ale wins over the translation fault
function automatic exc_code_t model_exc(input mem_op_t op, input logic [1:0] a,
                                        input exc_code_t tlb_exc);
    mem_size_t s;
    s = model_size(op);
    if ((s == size_word && a != 2'b00) || (s == size_half && a[0])) return exc_ale;
    return tlb_exc;
endfunction

task automatic check_word(input string what, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] exp, inout int errs);
    if (got !== exp) begin
        errs++;
        $display("FAIL %s expected %h actual %h", what, exp, got);
    end
endtask

task automatic check_size(input string what, input mem_size_t got, input mem_size_t exp,
                          inout int errs);
    if (got !== exp) begin
        errs++;
        $display("FAIL %s expected %s actual %s", what, exp.name(), got.name());
    end
endtask

task automatic check_exc(input string what, input exc_code_t got, input exc_code_t exp,
                         inout int errs);
    if (got !== exp) begin
        errs++;
        $display("FAIL %s expected %s actual %s", what, exp.name(), got.name());
    end
endtask

task automatic check_strb(input string what, input logic [3:0] got, input logic [3:0] exp,
                          inout int errs);
    if (got !== exp) begin
        errs++;
        $display("FAIL %s expected %b actual %b", what, exp, got);
    end
endtask

`endif

// ==== verif/tb_ex_mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_mem_stage import ex_pkg::*; import mmu_pkg::*; ();

    `include "tb_model.svh"

    localparam int dmw_count = 2;
    localparam int n_direct  = 40;
    localparam int n_window  = 40;
    localparam int n_page    = 40;
    localparam int n_ale     = 20;
    localparam int n_bp      = 30;
    localparam int n_flush   = 5;
    localparam int n_items   = n_direct + n_window + n_page + n_ale + n_bp + n_flush;

    logic                     clk = 1'b0;
    logic                     reset;
    logic                     in_valid;
    logic                     allow_in;
    logic [xlen-1:0]          in_pc;
    logic [xlen-1:0]          in_rj;
    logic [xlen-1:0]          in_imm;
    logic [xlen-1:0]          in_rkd;
    mem_op_t                  in_op;
    logic                     ms_allow_in;
    logic                     out_valid;
    logic [xlen-1:0]          out_pc;
    logic [xlen-1:0]          out_vaddr;
    exc_code_t                out_exc;
    logic                     data_sram_req;
    logic                     data_sram_wr;
    mem_size_t                data_sram_size;
    logic [3:0]               data_sram_wstrb;
    logic [xlen-1:0]          data_sram_addr;
    logic [xlen-1:0]          data_sram_wdata;
    logic                     data_uncache;
    logic                     data_sram_addr_ok;
    logic                     flush;
    logic                     crmd_da;
    logic                     crmd_pg;
    logic [1:0]               plv;
    logic [1:0]               datm;
    dmw_cfg_t [dmw_count-1:0] dmw;
    logic [18:0]              tlb_vppn;
    logic                     tlb_va_bit12;
    tlb_result_t              tlb;

    // the item being set up for the next issue
    logic        c_da;
    logic        c_pg;
    logic [1:0]  c_plv;
    logic [1:0]  c_datm;
    dmw_cfg_t    c_w0;
    dmw_cfg_t    c_w1;
    tlb_result_t c_tlb;
    mem_op_t     c_op;
    logic [31:0] c_va;
    logic [31:0] c_rkd;
    logic [31:0] c_pc;

    logic [31:0] rng;       // stimulus lfsr
    logic [31:0] rsp_rng;   // responder lfsr
    logic [31:0] next_pc;
    int          errs;

    ex_mem_stage #(.dmw_count(dmw_count)) i_dut (
        .clk               (clk),
        .reset             (reset),
        .in_valid          (in_valid),
        .allow_in          (allow_in),
        .in_pc             (in_pc),
        .in_rj             (in_rj),
        .in_imm            (in_imm),
        .in_rkd            (in_rkd),
        .in_op             (in_op),
        .ms_allow_in       (ms_allow_in),
        .out_valid         (out_valid),
        .out_pc            (out_pc),
        .out_vaddr         (out_vaddr),
        .out_exc           (out_exc),
        .data_sram_req     (data_sram_req),
        .data_sram_wr      (data_sram_wr),
        .data_sram_size    (data_sram_size),
        .data_sram_wstrb   (data_sram_wstrb),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_uncache      (data_uncache),
        .data_sram_addr_ok (data_sram_addr_ok),
        .flush             (flush),
        .crmd_da           (crmd_da),
        .crmd_pg           (crmd_pg),
        .plv               (plv),
        .datm              (datm),
        .dmw               (dmw),
        .tlb_vppn          (tlb_vppn),
        .tlb_va_bit12      (tlb_va_bit12),
        .tlb               (tlb)
    );

    always #4 clk = ~clk;

    // sram accepts on random cycles
    always @(posedge clk) begin
        rsp_rng = lfsr_step(rsp_rng);
        data_sram_addr_ok <= rsp_rng[0];
    end

    // newest bit lands in the lsb
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v   = {v[30:0], rng[0]};
        end
    endtask

    function automatic logic [31:0] align_addr(input mem_op_t op, input logic [31:0] va);
        if (model_size(op) == size_word) return {va[31:2], 2'b00};
        if (model_size(op) == size_half) return {va[31:1], 1'b0};
        return va;
    endfunction

    // random op, address, store data and next pc
    task automatic pick_access(input logic misalign);
        logic [31:0] v;
        draw_bits(3, v);
        c_op = mem_op_t'(v[2:0]);
        if (misalign && model_size(c_op) == size_byte) begin
            c_op = v[0] ? st_w : ld_h;   // a byte is never misaligned
        end
        draw_bits(32, v);
        c_va = align_addr(c_op, v);
        if (misalign && model_size(c_op) == size_half) begin
            c_va[0] = 1'b1;
        end else if (misalign) begin
            c_va[1:0] = (v[1:0] == 2'b00) ? 2'b10 : v[1:0];
        end
        draw_bits(32, c_rkd);
        c_pc    = next_pc;
        next_pc = next_pc + 32'd4;
    endtask

    // one posedge to present the item, one more to take it in
    task automatic issue_item(input logic first_allow);
        logic [31:0] rj;
        draw_bits(32, rj);
        @(posedge clk);
        in_valid    <= 1'b1;
        in_pc       <= c_pc;
        in_rj       <= rj;
        in_imm      <= c_va - rj;
        in_rkd      <= c_rkd;
        in_op       <= c_op;
        crmd_da     <= c_da;
        crmd_pg     <= c_pg;
        plv         <= c_plv;
        datm        <= c_datm;
        dmw         <= {c_w1, c_w0};
        tlb         <= c_tlb;
        ms_allow_in <= first_allow;
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic run_item(input string name, input logic bp);
        logic [31:0] v;
        logic [31:0] pa;
        logic        unc;
        logic        st;
        exc_code_t   texc;
        exc_code_t   exc;
        int          reqs;
        logic        done;
        st = (c_op == st_b || c_op == st_h || c_op == st_w);
        model_xlat(c_da, c_pg, c_plv, c_datm, c_w0, c_w1, c_tlb, c_va, st, pa, unc, texc);
        exc = model_exc(c_op, pa[1:0], texc);
        draw_bits(1, v);
        issue_item(bp ? v[0] : 1'b1);
        reqs = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (data_sram_req && !ms_allow_in) begin
                errs++;
                $display("%s: request raised while the next stage was not ready", name);
            end
            check_word({name, " held pc"}, out_pc, c_pc, errs);
            if (data_sram_req && data_sram_addr_ok) reqs++;
            if (out_valid) begin
                check_word({name, " vaddr"}, out_vaddr, c_va, errs);
                check_exc({name, " exc"}, out_exc, exc, errs);
                check_word({name, " vppn"}, {13'b0, tlb_vppn}, {13'b0, c_va[31:13]}, errs);
                check_word({name, " va bit12"}, {31'b0, tlb_va_bit12}, {31'b0, c_va[12]},
                           errs);
                if (exc == exc_none) begin
                    check_word({name, " addr"}, data_sram_addr, pa, errs);
                    check_size({name, " size"}, data_sram_size, model_size(c_op), errs);
                    check_strb({name, " wstrb"}, data_sram_wstrb,
                               model_wstrb(c_op, pa[1:0]), errs);
                    check_word({name, " wdata"}, data_sram_wdata,
                               model_wdata(c_op, c_rkd), errs);
                    check_word({name, " wr"}, {31'b0, data_sram_wr}, {31'b0, st}, errs);
                    check_word({name, " uncache"}, {31'b0, data_uncache}, {31'b0, unc}, errs);
                end else begin
                    check_word({name, " req"}, {31'b0, data_sram_req}, 32'd0, errs);
                end
                check_word({name, " requests"}, reqs, (exc == exc_none) ? 1 : 0, errs);
                done = 1'b1;
            end else begin
                if (allow_in) begin
                    errs++;
                    $display("%s: allow_in high while the item was held", name);
                end
                @(posedge clk);
                if (bp) begin
                    draw_bits(1, v);
                    ms_allow_in <= v[0];
                end
            end
        end
        @(negedge clk);   // item has left by now
        if (out_valid || !allow_in) begin
            errs++;
            $display("%s: stage did not empty after the item completed", name);
        end
    endtask

    // park an item behind back-pressure, then flush it
    task automatic flush_item(input string name);
        issue_item(1'b0);
        repeat (2) begin
            @(negedge clk);
            if (out_valid || data_sram_req) begin
                errs++;
                $display("%s: waiting item completed or requested", name);
            end
        end
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        if (out_valid || !allow_in) begin
            errs++;
            $display("%s: flushed item still in the stage", name);
        end
        @(posedge clk);
        ms_allow_in <= 1'b1;
        @(negedge clk);
        if (out_valid || data_sram_req) begin
            errs++;
            $display("%s: flushed item came out", name);
        end
    endtask

    task automatic set_direct();
        logic [31:0] v;
        c_da = 1'b1;
        c_pg = 1'b0;
        draw_bits(4, v);
        c_datm = v[1:0];
        c_plv  = v[3:2];
        c_w0   = '0;
        c_w1   = '0;
        c_tlb  = '0;
    endtask

    task automatic report_test(input string name, input int count, input int fails);
        $display("test %-12s %0d items, %0d errors", name, count, fails);
    endtask

    initial begin
        logic [31:0] v;
        int          start;
        reset             <= 1'b1;
        in_valid          <= 1'b0;
        in_pc             <= '0;
        in_rj             <= '0;
        in_imm            <= '0;
        in_rkd            <= '0;
        in_op             <= ld_b;
        ms_allow_in       <= 1'b1;
        data_sram_addr_ok <= 1'b0;
        flush             <= 1'b0;
        crmd_da           <= 1'b1;
        crmd_pg           <= 1'b0;
        plv               <= 2'd0;
        datm              <= 2'd0;
        dmw               <= '0;
        tlb               <= '0;
        rng               = 32'hf747;
        rsp_rng           = 32'hf747;
        next_pc           = 32'h1c00_0000;
        errs              = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        start = errs;
        for (int i = 0; i < n_direct; i++) begin
            set_direct();
            pick_access(1'b0);
            run_item("direct", 1'b0);
        end
        report_test("direct", n_direct, errs - start);

        start = errs;
        for (int i = 0; i < n_window; i++) begin
            c_da = 1'b0;
            c_pg = 1'b1;
            draw_bits(3, v);
            c_plv  = v[0] ? 2'd3 : 2'd0;
            c_datm = v[2:1];
            pick_access(1'b0);
            draw_bits(20, v);
            c_w0 = dmw_cfg_t'(v[9:0]);
            c_w1 = dmw_cfg_t'(v[19:10]);
            draw_bits(3, v);
            if (v[0]) c_w0.vseg = c_va[31:29];   // bias toward hits
            if (v[1]) c_w1.vseg = c_va[31:29];
            if (v[2]) begin
                c_w0.mat = c_datm;
                c_w1.mat = c_datm;
            end
            draw_bits(22, v);
            c_tlb       = '0;   // clean page for the misses
            c_tlb.found = 1'b1;
            c_tlb.ppn   = v[19:0];
            c_tlb.plv   = 2'd3;
            c_tlb.d     = 1'b1;
            c_tlb.v     = 1'b1;
            c_tlb.mat   = v[21:20];
            run_item("window", 1'b0);
        end
        report_test("window", n_window, errs - start);

        start = errs;
        for (int i = 0; i < n_page; i++) begin
            c_da = 1'b0;
            c_pg = 1'b1;
            draw_bits(4, v);
            c_plv  = v[1:0];
            c_datm = v[3:2];
            c_w0   = '0;   // no privilege bit, no window hit
            c_w1   = '0;
            draw_bits(27, v);
            c_tlb = tlb_result_t'(v[26:0]);
            pick_access(1'b0);
            run_item("page", 1'b0);
        end
        report_test("page", n_page, errs - start);

        start = errs;
        for (int i = 0; i < n_ale; i++) begin
            set_direct();
            draw_bits(28, v);
            if (v[0]) begin
                c_da  = 1'b0;   // page mapping, ale must win
                c_pg  = 1'b1;
                c_tlb = tlb_result_t'(v[27:1]);
            end
            pick_access(1'b1);
            run_item("misaligned", 1'b0);
        end
        report_test("misaligned", n_ale, errs - start);

        start = errs;
        for (int i = 0; i < n_bp; i++) begin
            set_direct();
            pick_access(1'b0);
            run_item("backpressure", 1'b1);
        end
        report_test("backpressure", n_bp, errs - start);

        start = errs;
        for (int i = 0; i < n_flush; i++) begin
            set_direct();
            pick_access(1'b0);
            flush_item("flush");
        end
        report_test("flush", n_flush, errs - start);

        $display("%0d items run, %0d errors", n_items, errs);
        if (errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        repeat (n_items * 40) @(posedge clk);
        $display("watchdog: tests did not finish within %0d cycles", n_items * 40);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ex_mem_stage.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/mmu_pkg.sv
verilog/xlat_if.sv
verilog/ex_stage_reg.sv
verilog/addr_translate.sv
verilog/mem_req_gen.sv
verilog/ex_mem_stage.sv
verif/tb_ex_mem_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ex_mem_stage testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -f ex_mem_stage.f --top-module tb_ex_mem_stage -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "SIMULATION FAILED" "$log"; then
    exit 1
fi
exit 0
